//--- bench/rs_station_tb.sv
/*
 * Directed testbench for the reservation station
 * Clock and reset, LFSR operand source, compare tasks, test tasks, summary
 */

`timescale 1ns/10ps
`include "rs_params.svh"

module rs_station_tb import rs_pkg::*; ();

	localparam int LFSR_SEED = 77862;
	localparam int TIMEOUT   = 20;           // Cycles per wait loop

	logic                      clock = 1'b0;
	logic                      rst;
	rs_disp_t                  disp1;
	rs_disp_t                  disp2;
	logic                      load1;
	logic                      load2;
	cdb_t                      cdb1;
	cdb_t                      cdb2;
	logic      [`FU_SLOTS-1:0] fu_available;
	logic                      flush_t0;
	logic                      flush_t1;
	rs_issue_t [`FU_SLOTS-1:0] issue;
	logic      [`FU_SLOTS-1:0] issue_valid;
	logic                      rs_full;

	logic [15:0] lfsr;
	string       cur_test;
	int          test_errs;
	int          total_errs;
	int          tests_run;
	int          tests_bad;

	always #4 clock = ~clock;

	rs_station rs_station_inst (.*);

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////////////////////////

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsr_step()};
		return v;
	endfunction

	// Ready instruction with random operands
	function automatic rs_disp_t make_disp(input fu_sel_e fu, input logic [`ROB_W-1:0] rob);
		rs_disp_t    d;
		logic [63:0] t;
		d.opa       = rand_bits(`DATA_W);
		d.opa_valid = 1'b1;
		d.opb       = rand_bits(`DATA_W);
		d.opb_valid = 1'b1;
		t           = rand_bits(12);
		d.dest_tag  = t[11:6];
		d.op_type   = t[5:0];
		d.rob_idx   = rob;
		d.alu_func  = (fu == FU_MULT) ? ALU_MULQ : ALU_ADD;
		d.fu_sel    = fu;
		return d;
	endfunction

	function automatic logic [`DATA_W-1:0] tag_word(input logic [`TAG_W-1:0] tag);
		return {{(`DATA_W - `TAG_W){1'b0}}, tag};
	endfunction

	// What a function unit should see for a dispatched instruction
	function automatic rs_issue_t to_issue(input rs_disp_t d);
		rs_issue_t e;
		e.opa      = d.opa;
		e.opb      = d.opb;
		e.dest_tag = d.dest_tag;
		e.rob_idx  = d.rob_idx;
		e.op_type  = d.op_type;
		e.alu_func = d.alu_func;
		return e;
	endfunction

	function automatic int first_valid_slot();
		int f;
		f = -1;
		for (int s = `FU_SLOTS - 1; s >= 0; s--)
			if (issue_valid[s])
				f = s;
		return f;
	endfunction

	task automatic clear_inputs();
		load1    = 1'b0;
		load2    = 1'b0;
		cdb1     = '0;
		cdb2     = '0;
		flush_t0 = 1'b0;
		flush_t1 = 1'b0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Checking
	//////////////////////////////////////////////////////////////////////

	task automatic note_error();
		test_errs++;
		total_errs++;
	endtask

	task automatic compare_issue(input string what, input rs_issue_t exp, input rs_issue_t act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic compare_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Fail %s %s: expected %b, actual %b", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic compare_slot(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("Fail %s %s: expected slot %0d, actual slot %0d", cur_test, what, exp, act);
			note_error();
		end
	endtask

	task automatic check_mask(input string what, input logic [`FU_SLOTS-1:0] exp);
		for (int s = 0; s < `FU_SLOTS; s++)
			compare_bit($sformatf("%s issue_valid[%0d]", what, s), exp[s], issue_valid[s]);
	endtask

	// Sits at the sample point, half a clock phase after the falling edge
	task automatic wait_issue(input int slot);
		int n;
		n = 0;
		while (!issue_valid[slot] && n < TIMEOUT) begin
			@(negedge clock);
			#2;
			n++;
		end
		if (!issue_valid[slot]) begin
			$display("Timeout in %s: slot %0d issued nothing within %0d cycles",
				cur_test, slot, TIMEOUT);
			note_error();
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0)
			tests_bad++;
		$display("%s: %0d errors", cur_test, test_errs);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset();
		start_test("reset");
		@(negedge clock);
		fu_available = '1;
		#2;
		check_mask("idle", '0);
		compare_bit("rs_full", 1'b0, rs_full);
		finish_test();
	endtask

	// ALU goes to slot 1, memory to slot 4
	task automatic test_ready_dispatch();
		rs_disp_t d_alu;
		rs_disp_t d_mem;
		start_test("ready_dispatch");
		d_alu = make_disp(FU_ALU, 6'd1);
		d_mem = make_disp(FU_MEM, 6'd2);
		@(negedge clock);
		{disp1, load1} = {d_alu, 1'b1};
		{disp2, load2} = {d_mem, 1'b1};
		@(negedge clock);
		clear_inputs();
		#2;
		check_mask("after load", 6'b010010);
		compare_issue("slot 1", to_issue(d_alu), issue[1]);
		compare_issue("slot 4", to_issue(d_mem), issue[4]);
		@(negedge clock);
		#2;
		check_mask("after issue", '0);
		finish_test();
	endtask

	task automatic test_wakeup();
		rs_disp_t  d;
		rs_issue_t e;
		logic [63:0] va;
		logic [63:0] vb1;
		logic [63:0] vb2;
		start_test("wakeup");
		d = make_disp(FU_ALU, 6'd3);
		{d.opa_valid, d.opa} = {1'b0, tag_word(6'd10)};
		{d.opb_valid, d.opb} = {1'b0, tag_word(6'd11)};
		va  = rand_bits(64);
		vb1 = rand_bits(64);
		vb2 = ~vb1;
		@(negedge clock);
		{disp1, load1} = {d, 1'b1};
		@(negedge clock);
		clear_inputs();
		cdb2 = {1'b1, 6'd10, va};               // opa broadcast
		#2;
		check_mask("waiting", '0);
		@(negedge clock);
		cdb1 = {1'b1, 6'd11, vb1};              // Both buses carry opb
		cdb2 = {1'b1, 6'd11, vb2};
		#2;
		check_mask("opa only", '0);
		@(negedge clock);
		clear_inputs();
		#2;
		wait_issue(1);
		e     = to_issue(d);
		e.opa = va;
		e.opb = vb1;
		compare_issue("slot 1", e, issue[1]);
		@(negedge clock);
		#2;
		check_mask("after issue", '0);
		finish_test();
	endtask

	task automatic test_bypass();
		rs_disp_t  d;
		rs_issue_t e;
		logic [63:0] v;
		start_test("dispatch_bypass");
		d = make_disp(FU_MEM, 6'd4);
		{d.opb_valid, d.opb} = {1'b0, tag_word(6'd20)};
		v = rand_bits(64);
		@(negedge clock);
		{disp1, load1} = {d, 1'b1};
		cdb1 = {1'b1, 6'd20, v};                // Same cycle as load
		@(negedge clock);
		clear_inputs();
		#2;
		compare_slot("first issue", 4, first_valid_slot());
		e     = to_issue(d);
		e.opb = v;
		compare_issue("slot 4", e, issue[4]);
		@(negedge clock);
		#2;
		check_mask("after issue", '0);
		finish_test();
	endtask

	// Multipliers live on slots 0 and 2
	task automatic test_backpressure();
		rs_disp_t m [3];
		start_test("slot_backpressure");
		for (int i = 0; i < 3; i++)
			m[i] = make_disp(FU_MULT, 6'(8 + i));
		@(negedge clock);
		fu_available = '0;
		{disp1, load1} = {m[0], 1'b1};
		{disp2, load2} = {m[1], 1'b1};
		@(negedge clock);
		load2 = 1'b0;
		disp1 = m[2];
		#2;
		check_mask("all units busy", '0);
		@(negedge clock);
		clear_inputs();
		fu_available = 6'b000100;
		#2;
		compare_bit("rs_full", 1'b0, rs_full);
		check_mask("slot 2 only", 6'b000100);
		compare_slot("first issue", 2, first_valid_slot());
		compare_issue("slot 2 entry 0", to_issue(m[0]), issue[2]);
		@(negedge clock);
		fu_available = 6'b000101;
		#2;
		check_mask("slots 0 and 2", 6'b000101);
		compare_issue("slot 0 entry 1", to_issue(m[1]), issue[0]);
		compare_issue("slot 2 entry 2", to_issue(m[2]), issue[2]);
		@(negedge clock);
		fu_available = '1;
		#2;
		check_mask("drained", '0);
		finish_test();
	endtask

	task automatic test_full_flush();
		rs_issue_t q [$];
		rs_disp_t  d;
		int        n;
		start_test("full_flush");
		@(negedge clock);
		fu_available = '0;
		for (int k = 0; k < 4; k++) begin
			if (k > 0)
				@(negedge clock);
			d = make_disp(FU_ALU, {1'b0, 5'(k)});     // Thread 0 on lane 1
			q.push_back(to_issue(d));
			{disp1, load1} = {d, 1'b1};
			{disp2, load2} = {make_disp(FU_ALU, {1'b1, 5'(k)}), k < 3};
			#2;
			compare_bit($sformatf("rs_full before load %0d", k), 1'b0, rs_full);
		end
		@(negedge clock);
		clear_inputs();
		#2;
		compare_bit("rs_full with one free", 1'b1, rs_full);
		@(negedge clock);
		flush_t1 = 1'b1;
		@(negedge clock);
		flush_t1 = 1'b0;
		#2;
		compare_bit("rs_full after flush", 1'b0, rs_full);
		check_mask("units busy", '0);
		@(negedge clock);
		fu_available = '1;
		#2;
		n = 0;
		while (q.size() > 0 && n < TIMEOUT) begin
			for (int s = 0; s < `FU_SLOTS; s++) begin
				if (issue_valid[s] && q.size() == 0) begin
					$display("%s: slot %0d issued an extra instruction", cur_test, s);
					note_error();
				end else if (issue_valid[s]) begin
					compare_issue($sformatf("slot %0d", s), q.pop_front(), issue[s]);
				end
			end
			@(negedge clock);
			#2;
			n++;
		end
		if (q.size() > 0) begin
			$display("Timeout in %s: %0d thread 0 instructions never issued", cur_test, q.size());
			note_error();
		end
		check_mask("after drain", '0);
		finish_test();
	endtask

	initial begin
		lfsr       = LFSR_SEED[15:0];        // Seed folded to the register width
		total_errs = 0;
		tests_run  = 0;
		tests_bad  = 0;
		rst        = 1'b1;
		disp1      = '0;
		disp2      = '0;
		fu_available = '1;
		clear_inputs();
		repeat (4) @(negedge clock);
		rst = 1'b0;
		test_reset();
		test_ready_dispatch();
		test_wakeup();
		test_bypass();
		test_backpressure();
		test_full_flush();
		$display("%0d tests run, %0d with errors, %0d failed checks",
			tests_run, tests_bad, total_errs);
		if (total_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- common/rs_params.svh
/*
 * Sizing macros for the reservation station
 * Entry count, register tags, ROB index, operand width, issue slots
 */

`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// Station and machine sizes
`define RS_SIZE   8
`define PRF_SIZE  64
`define ROB_SIZE  32
`define DATA_W    64
`define FU_SLOTS  6

// Physical register tag width
`define TAG_W     $clog2(`PRF_SIZE)

// ROB index width, the extra top bit selects the thread
`define ROB_W     ($clog2(`ROB_SIZE) + 1)

`endif

//--- common/rs_pkg.sv
/*
 * Shared types for the reservation station
 * ALU function and unit kind enums, dispatch / CDB / issue structs,
 * slot to unit kind mapping
 */

`include "rs_params.svh"

package rs_pkg;

	typedef enum logic [4:0] {
		ALU_ADD,              // Default function
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_MULQ
	} alu_func_e;

	typedef enum logic [1:0] {
		FU_MULT,
		FU_ALU,
		FU_MEM
	} fu_sel_e;

	// One renamed instruction from the dispatcher
	typedef struct packed {
		logic [`TAG_W-1:0]  dest_tag;
		logic [`DATA_W-1:0] opa;        // Tag in low bits when opa_valid is clear
		logic               opa_valid;
		logic [`DATA_W-1:0] opb;        // Tag in low bits when opb_valid is clear
		logic               opb_valid;
		logic [`ROB_W-1:0]  rob_idx;
		alu_func_e          alu_func;
		logic [5:0]         op_type;
		fu_sel_e            fu_sel;
	} rs_disp_t;

	typedef struct packed {
		logic               valid;
		logic [`TAG_W-1:0]  tag;
		logic [`DATA_W-1:0] value;
	} cdb_t;

	// Instruction as handed to a function unit
	typedef struct packed {
		logic [`DATA_W-1:0] opa;
		logic [`DATA_W-1:0] opb;
		logic [`TAG_W-1:0]  dest_tag;
		logic [`ROB_W-1:0]  rob_idx;
		logic [5:0]         op_type;
		alu_func_e          alu_func;
	} rs_issue_t;

	// Slots 0 and 2 multiply, 1 and 3 are ALUs, 4 and 5 memory
	function automatic fu_sel_e slot_kind(input int unsigned slot);
		if (slot >= 4)
			slot_kind = FU_MEM;
		else if (slot % 2 == 0)
			slot_kind = FU_MULT;
		else
			slot_kind = FU_ALU;
	endfunction

endpackage

//--- rs/rs_alloc.sv
/*
 * Dispatch allocator
 * Two lowest free entries for the two dispatch slots, full flag
 */

`timescale 1ns/10ps
`include "rs_params.svh"

module rs_alloc (
	input  logic                clock,
	input  logic                rst,
	input  logic [`RS_SIZE-1:0] free_vec,
	input  logic                load1,
	input  logic                load2,
	output logic [`RS_SIZE-1:0] load_sel1,   // One-hot or zero
	output logic [`RS_SIZE-1:0] load_sel2,   // One-hot or zero
	output logic                rs_full
);

	logic [`RS_SIZE-1:0] first_free;
	logic [`RS_SIZE-1:0] rest_free;
	logic [`RS_SIZE-1:0] second_free;

	// x & -x keeps only the lowest set bit
	assign first_free  = free_vec & (~free_vec + 1'b1);
	assign rest_free   = free_vec & ~first_free;
	assign second_free = rest_free & (~rest_free + 1'b1);

	assign load_sel1 = load1 ? first_free : '0;
	assign load_sel2 = load2 ? second_free : '0;   // Even without load1

	// Fewer than two entries free
	assign rs_full = (second_free == '0);

	//////////////////////////////////////////////////////////////////////
	// Dispatch protocol checks
	//////////////////////////////////////////////////////////////////////

	no_load_when_full_a: assert property (@(posedge clock) disable iff (rst)
		(load1 || load2) |-> !rs_full)
		else $error("rs_alloc: dispatch while rs_full");

	grants_distinct_a: assert property (@(posedge clock) disable iff (rst)
		(load_sel1 & load_sel2) == '0)
		else $error("rs_alloc: both dispatch slots got the same entry");

endmodule

//--- rs/rs_entry.sv
/*
 * Single reservation station entry
 * Dispatch-time CDB bypass, CDB wakeup of waiting operands,
 * release on issue grant or on a flush of the owning thread
 */

`timescale 1ns/10ps
`include "rs_params.svh"

module rs_entry import rs_pkg::*; (
	input  logic      clock,
	input  logic      rst,
	input  logic      load,          // Allocator picked this entry
	input  rs_disp_t  disp,
	input  cdb_t      cdb1,
	input  cdb_t      cdb2,
	input  logic      issue_grant,   // Taken by a function unit slot this cycle
	input  logic      flush_t0,
	input  logic      flush_t1,
	output logic      free,
	output logic      ready,
	output fu_sel_e   fu_sel,
	output logic      thread,
	output rs_issue_t entry_out
);

	logic               occupied;
	logic [`DATA_W-1:0] opa;
	logic               opa_valid;
	logic [`DATA_W-1:0] opb;
	logic               opb_valid;
	logic [`TAG_W-1:0]  dest_tag;
	logic [`ROB_W-1:0]  rob_idx;
	alu_func_e          alu_func;
	logic [5:0]         op_type;

	logic [`DATA_W:0]   opa_in;        // {valid, value} of incoming operands
	logic [`DATA_W:0]   opb_in;
	logic [`DATA_W:0]   opa_wake;      // {valid, value} of stored operands
	logic [`DATA_W:0]   opb_wake;
	logic               flush_hit;
	logic               load_kill;

	// Operand capture, CDB1 wins over CDB2
	function automatic logic [`DATA_W:0] capture(
		input logic [`DATA_W-1:0] value,
		input logic               valid,
		input cdb_t               c1,
		input cdb_t               c2
	);
		logic [`TAG_W-1:0] tag;
		tag = value[`TAG_W-1:0];
		if (valid)
			capture = {1'b1, value};
		else if (c1.valid && c1.tag == tag)
			capture = {1'b1, c1.value};
		else if (c2.valid && c2.tag == tag)
			capture = {1'b1, c2.value};
		else
			capture = {1'b0, value};
	endfunction

	assign opa_in   = capture(disp.opa, disp.opa_valid, cdb1, cdb2);
	assign opb_in   = capture(disp.opb, disp.opb_valid, cdb1, cdb2);
	assign opa_wake = capture(opa, opa_valid, cdb1, cdb2);
	assign opb_wake = capture(opb, opb_valid, cdb1, cdb2);

	assign flush_hit = occupied && (thread ? flush_t1 : flush_t0);
	assign load_kill = disp.rob_idx[`ROB_W-1] ? flush_t1 : flush_t0; // Flush beats load

	//////////////////////////////////////////////////////////////////////
	// Occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (rst)
			occupied <= 1'b0;
		else if (load)
			occupied <= !load_kill;
		else if (flush_hit || issue_grant)
			occupied <= 1'b0;
	end

	// Payload and operand state
	always_ff @(posedge clock) begin
		if (load) begin
			{opa_valid, opa} <= opa_in;
			{opb_valid, opb} <= opb_in;
			dest_tag         <= disp.dest_tag;
			rob_idx          <= disp.rob_idx;
			alu_func         <= disp.alu_func;
			op_type          <= disp.op_type;
			fu_sel           <= disp.fu_sel;
		end else if (occupied) begin
			{opa_valid, opa} <= opa_wake;   // Wakeup while waiting
			{opb_valid, opb} <= opb_wake;
		end
	end

	assign free   = !occupied;
	assign ready  = occupied && opa_valid && opb_valid;
	assign thread = rob_idx[`ROB_W-1];

	always_comb begin
		entry_out.opa      = opa;
		entry_out.opb      = opb;
		entry_out.dest_tag = dest_tag;
		entry_out.rob_idx  = rob_idx;
		entry_out.op_type  = op_type;
		entry_out.alu_func = alu_func;
	end

	// The allocator only hands out entries that are free
	load_when_free_a: assert property (@(posedge clock) disable iff (rst)
		load |-> !occupied)
		else $error("rs_entry: load while occupied");

endmodule

//--- rs/rs_issue_select.sv
/*
 * Issue selector
 * Maps ready entries onto the six function unit slots,
 * lowest entry index first, and returns per-entry grants
 */

`timescale 1ns/10ps
`include "rs_params.svh"

module rs_issue_select import rs_pkg::*; (
	input  logic                         clock,
	input  logic                         rst,
	input  logic      [`RS_SIZE-1:0]     ready_vec,
	input  fu_sel_e   [`RS_SIZE-1:0]     fu_sel_vec,
	input  rs_issue_t [`RS_SIZE-1:0]     entry_vec,
	input  logic      [`FU_SLOTS-1:0]    fu_available,   // Level per slot
	output rs_issue_t [`FU_SLOTS-1:0]    issue,
	output logic      [`FU_SLOTS-1:0]    issue_valid,
	output logic      [`RS_SIZE-1:0]     issue_grant
);

	//////////////////////////////////////////////////////////////////////
	// Slot walk
	//////////////////////////////////////////////////////////////////////

	// Slot 0 looks first, so an entry taken there is hidden from slot 2
	always_comb begin
		logic                found;
		logic [`RS_SIZE-1:0] taken;
		found       = 1'b0;
		taken       = '0;
		issue       = '0;
		issue_valid = '0;
		for (int s = 0; s < `FU_SLOTS; s++) begin
			found = 1'b0;
			if (fu_available[s]) begin
				for (int i = 0; i < `RS_SIZE; i++) begin
					if (!found && ready_vec[i] && !taken[i] &&
						fu_sel_vec[i] == slot_kind(s)) begin
						found          = 1'b1;
						taken[i]       = 1'b1;
						issue[s]       = entry_vec[i];
						issue_valid[s] = 1'b1;
					end
				end
			end
		end
		issue_grant = taken;   // Entry frees itself at the next edge
	end

	// Every issued slot frees exactly one entry
	grant_count_a: assert property (@(posedge clock) disable iff (rst)
		$countones(issue_grant) == $countones(issue_valid))
		else $error("rs_issue_select: grant count differs from issue count");

endmodule

//--- rs/rs_station.sv
/*
 * Unified reservation station, two-wide dispatch, six issue slots
 * Entry array, dispatch allocator and issue selector
 */

`timescale 1ns/10ps
`include "rs_params.svh"

module rs_station import rs_pkg::*; (
	input  logic                      clock,
	input  logic                      rst,
	input  rs_disp_t                  disp1,
	input  logic                      load1,
	input  rs_disp_t                  disp2,
	input  logic                      load2,
	input  cdb_t                      cdb1,
	input  cdb_t                      cdb2,
	input  logic      [`FU_SLOTS-1:0] fu_available,
	input  logic                      flush_t0,       // Thread 0 branch taken
	input  logic                      flush_t1,       // Thread 1 branch taken
	output rs_issue_t [`FU_SLOTS-1:0] issue,
	output logic      [`FU_SLOTS-1:0] issue_valid,
	output logic                      rs_full
);

	logic      [`RS_SIZE-1:0] free_vec;
	logic      [`RS_SIZE-1:0] ready_vec;
	logic      [`RS_SIZE-1:0] thread_vec;
	logic      [`RS_SIZE-1:0] load_sel1;
	logic      [`RS_SIZE-1:0] load_sel2;
	logic      [`RS_SIZE-1:0] issue_grant;
	fu_sel_e   [`RS_SIZE-1:0] fu_sel_vec;
	rs_issue_t [`RS_SIZE-1:0] entry_vec;

	//////////////////////////////////////////////////////////////////////
	// Entry array
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `RS_SIZE; i++) begin : entry_gen
		rs_disp_t entry_disp;
		logic     entry_load;

		assign entry_load = load_sel1[i] || load_sel2[i];
		assign entry_disp = load_sel2[i] ? disp2 : disp1;

		rs_entry entry_inst (
			.clock       (clock),
			.rst         (rst),
			.load        (entry_load),
			.disp        (entry_disp),
			.cdb1        (cdb1),
			.cdb2        (cdb2),
			.issue_grant (issue_grant[i]),
			.flush_t0    (flush_t0),
			.flush_t1    (flush_t1),
			.free        (free_vec[i]),
			.ready       (ready_vec[i]),
			.fu_sel      (fu_sel_vec[i]),
			.thread      (thread_vec[i]),
			.entry_out   (entry_vec[i])
		);
	end

	rs_alloc alloc_inst (
		.clock     (clock),
		.rst       (rst),
		.free_vec  (free_vec),
		.load1     (load1),
		.load2     (load2),
		.load_sel1 (load_sel1),
		.load_sel2 (load_sel2),
		.rs_full   (rs_full)
	);

	rs_issue_select select_inst (
		.clock        (clock),
		.rst          (rst),
		.ready_vec    (ready_vec),
		.fu_sel_vec   (fu_sel_vec),
		.entry_vec    (entry_vec),
		.fu_available (fu_available),
		.issue        (issue),
		.issue_valid  (issue_valid),
		.issue_grant  (issue_grant)
	);

	// No entry of a flushed thread survives the flush edge
	flush_t0_a: assert property (@(posedge clock) disable iff (rst)
		flush_t0 |=> ((~thread_vec & ~free_vec) == '0))
		else $error("rs_station: thread 0 entry left after flush");

	flush_t1_a: assert property (@(posedge clock) disable iff (rst)
		flush_t1 |=> ((thread_vec & ~free_vec) == '0))
		else $error("rs_station: thread 1 entry left after flush");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module rs_station_tb -o rs_station_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/rs_station_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "Simulation exited with an error"
	exit 1
fi

cat sim.log
if grep -q "tests failed" sim.log; then
	exit 1
fi
if ! grep -q "all tests passed" sim.log; then
	echo "Simulation ended without a result line"
	exit 1
fi
exit 0

//--- vlog.f
+incdir+common
common/rs_pkg.sv
rs/rs_entry.sv
rs/rs_alloc.sv
rs/rs_issue_select.sv
rs/rs_station.sv
bench/rs_station_tb.sv
